//--- rayTracer_settings.svh
`ifndef RAYTRACER_SETTINGS_SVH
`define RAYTRACER_SETTINGS_SVH

// Fixed-point scalar format
`define FIXED_WIDTH 32
`define FIXED_FRAC 16

// Finished rays waiting for the consumer
`define OUT_FIFO_DEPTH 4

`endif

//--- rayTypesPkg.sv
`include "rayTracer_settings.svh"

package rayTypesPkg;

    // --------------------------------------------------
    // Scalar and vector
    // --------------------------------------------------

    // Signed, FIXED_FRAC bits below the binary point
    typedef logic signed [`FIXED_WIDTH-1:0] fixedT;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } fixed3T;

    // --------------------------------------------------
    // Ray records
    // --------------------------------------------------

    // invDir is filled in by the generator, the rest passes through
    typedef struct packed {
        fixed3T origin;
        fixed3T dir;
        fixed3T invDir;
    } surfaceRayT;

    // Ray plus the bookkeeping that travels with it
    typedef struct packed {
        surfaceRayT ray;
        logic [15:0] pixelIndex;
        logic [3:0] bounceDepth;
    } surfaceInputT;

endpackage

//--- fixedReciprocal.sv
`include "rayTracer_settings.svh"

module fixedReciprocal (
    input  logic               clk,
    input  logic               resetn,
    input  logic               strobe,
    input  rayTypesPkg::fixedT x,
    output logic               valid,
    output rayTypesPkg::fixedT y
);
    import rayTypesPkg::*;

    localparam int width = `FIXED_WIDTH;
    localparam int leadBit = 2 * `FIXED_FRAC;
    localparam int countW = $clog2(width);
    localparam logic [width:0] dividendOne = {{width{1'b0}}, 1'b1};
    // One in the 2*FRAC format, i.e. the numerator of 1/x
    localparam logic [width:0] dividend = dividendOne << leadBit;
    localparam fixedT maxPos = {1'b0, {(width-1){1'b1}}};
    localparam fixedT minNeg = {1'b1, {(width-1){1'b0}}};

    logic busy;
    logic [countW-1:0] stepCount;
    logic lastStep;
    logic [width-1:0] magIn, mag, rem, quo;
    logic negative, topOne;
    logic [width-1:0] shifted, stepRem, stepQuo;
    logic stepBit;

    function automatic fixedT applySign(input logic [width-1:0] q, input logic neg,
                                        input logic top);
        if (neg) begin
            applySign = (top || q[width-1]) ? minNeg : fixedT'(~q + 1'b1);
        end else begin
            applySign = (top || q[width-1]) ? maxPos : fixedT'(q);
        end
    endfunction

    assign magIn = x[width-1] ? (~x + 1'b1) : x;
    assign lastStep = stepCount == countW'(width - 1);

    // One restoring step, quotient bits shift in from the right
    always_comb begin
        shifted = {rem[width-2:0], quo[width-1]};
        stepBit = shifted >= mag;
        stepRem = stepBit ? shifted - mag : shifted;
        stepQuo = {quo[width-2:0], stepBit};
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy <= 1'b0;
            valid <= 1'b0;
            stepCount <= '0;
        end else begin
            valid <= 1'b0;
            if (strobe) begin
                busy <= 1'b1;
                stepCount <= '0;
            end else if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (lastStep) begin
                    busy <= 1'b0;
                    valid <= 1'b1;
                end
            end
        end
    end

    // Top dividend bit is handled on load, magnitudes 0 and 1 overflow
    always_ff @(posedge clk) begin
        if (strobe) begin
            mag <= magIn;
            negative <= x[width-1];
            topOne <= dividend[width] && (magIn <= 1);
            rem <= {{(width-1){1'b0}}, dividend[width] && (magIn > 1)};
            quo <= dividend[width-1:0];
        end else if (busy) begin
            rem <= stepRem;
            quo <= stepQuo;
            if (lastStep) begin
                y <= applySign(stepQuo, negative, topOne);
            end
        end
    end

    // A new operand only once the previous one has finished
    assert property (@(posedge clk) disable iff (!resetn) strobe |-> !busy);

endmodule

//--- fixed3Reciprocal.sv
module fixed3Reciprocal (
    input  logic                clk,
    input  logic                resetn,
    input  logic                strobe,
    input  rayTypesPkg::fixed3T v,
    output logic                valid,
    output rayTypesPkg::fixed3T ov
);
    import rayTypesPkg::*;

    fixedT heldY, heldZ;
    fixedT divX, divY;
    logic divStrobe, divValid;
    // Component currently inside the divider
    logic [1:0] comp;

    // x starts straight away, y and z follow on the divider's valid
    assign divStrobe = strobe || (divValid && comp != 2'd2);
    assign divX = strobe ? v.x : ((comp == 2'd0) ? heldY : heldZ);

    fixedReciprocal divider_i (
        .clk(clk),
        .resetn(resetn),
        .strobe(divStrobe),
        .x(divX),
        .valid(divValid),
        .y(divY)
    );

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            comp <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (strobe) begin
                comp <= '0;
            end else if (divValid) begin
                if (comp == 2'd2) begin
                    comp <= '0;
                    valid <= 1'b1;
                end else begin
                    comp <= comp + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            heldY <= v.y;
            heldZ <= v.z;
        end
        if (divValid) begin
            case (comp)
                2'd0: ov.x <= divY;
                2'd1: ov.y <= divY;
                default: ov.z <= divY;
            endcase
        end
    end

endmodule

//--- surfaceRayGenerator.sv
module surfaceRayGenerator (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      addInput,
    input  logic                      addRefInput,
    input  rayTypesPkg::surfaceInputT inputData,
    input  rayTypesPkg::surfaceInputT refInputData,
    input  logic                      fifoFull,
    output logic                      inputFull,
    output logic                      refInputFull,
    output logic                      push,
    output rayTypesPkg::surfaceInputT pushData
);
    import rayTypesPkg::*;

    typedef enum logic [1:0] {
        genIdle,
        genGenerate,
        genDone
    } genStateT;

    genStateT state;
    surfaceInputT inputSlot, refInputSlot;
    // Ray being worked on
    surfaceInputT current;
    logic invStrobe, invValid;
    fixed3T invDir;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            inputFull <= 1'b0;
            refInputFull <= 1'b0;
            invStrobe <= 1'b0;
            state <= genIdle;
        end else begin
            invStrobe <= 1'b0;
            if (addInput && !inputFull) begin
                inputFull <= 1'b1;
            end
            if (addRefInput && !refInputFull) begin
                refInputFull <= 1'b1;
            end

            case (state)
                genIdle: begin
                    // Reflection rays go first
                    if (refInputFull) begin
                        refInputFull <= 1'b0;
                        invStrobe <= 1'b1;
                        state <= genGenerate;
                    end else if (inputFull) begin
                        inputFull <= 1'b0;
                        invStrobe <= 1'b1;
                        state <= genGenerate;
                    end
                end
                genGenerate: begin
                    if (invValid) begin
                        state <= genDone;
                    end
                end
                genDone: begin
                    if (!fifoFull) begin
                        state <= genIdle;
                    end
                end
                default: state <= genIdle;
            endcase
        end
    end

    // --------------------------------------------------
    // Slots and held ray
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (addInput && !inputFull) begin
            inputSlot <= inputData;
        end
        if (addRefInput && !refInputFull) begin
            refInputSlot <= refInputData;
        end
        if (state == genIdle) begin
            if (refInputFull) begin
                current <= refInputSlot;
            end else if (inputFull) begin
                current <= inputSlot;
            end
        end else if (state == genGenerate && invValid) begin
            current.ray.invDir <= invDir;
        end
    end

    assign push = (state == genDone) && !fifoFull;
    assign pushData = current;

    fixed3Reciprocal invDir_i (
        .clk(clk),
        .resetn(resetn),
        .strobe(invStrobe),
        .v(current.ray.dir),
        .valid(invValid),
        .ov(invDir)
    );

    // Sources must wait for their slot to drain
    assert property (@(posedge clk) disable iff (!resetn) addInput |-> !inputFull);
    assert property (@(posedge clk) disable iff (!resetn) addRefInput |-> !refInputFull);
    // Reciprocal result only while we are waiting for it
    assert property (@(posedge clk) disable iff (!resetn) invValid |-> state == genGenerate);

endmodule

//--- rayOutputFifo.sv
`include "rayTracer_settings.svh"

module rayOutputFifo (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      push,
    input  rayTypesPkg::surfaceInputT pushData,
    output logic                      full,
    input  logic                      read,
    output logic                      empty,
    output rayTypesPkg::surfaceInputT headData
);
    import rayTypesPkg::*;

    localparam int fifoDepth = `OUT_FIFO_DEPTH;
    localparam int ptrW = $clog2(fifoDepth);
    localparam int countW = $clog2(fifoDepth + 1);

    surfaceInputT mem [fifoDepth];
    logic [ptrW-1:0] wrPtr, rdPtr;
    logic [countW-1:0] count;

    // Pointer wrap, depth need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
        nextPtr = (p == ptrW'(fifoDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = count == countW'(fifoDepth);
    assign empty = count == '0;
    assign headData = mem[rdPtr];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (read) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) push |-> !full);
    assert property (@(posedge clk) disable iff (!resetn) read |-> !empty);

endmodule

//--- surfaceRayStage.sv
module surfaceRayStage (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      addInput,
    input  logic                      addRefInput,
    input  rayTypesPkg::surfaceInputT inputData,
    input  rayTypesPkg::surfaceInputT refInputData,
    output logic                      inputFull,
    output logic                      refInputFull,
    input  logic                      outRead,
    output logic                      outEmpty,
    output rayTypesPkg::surfaceInputT outData
);
    import rayTypesPkg::*;

    // Generator to FIFO
    logic fifoFull;
    logic push;
    surfaceInputT pushData;

    surfaceRayGenerator surfaceRayGenerator_i (
        .clk(clk),
        .resetn(resetn),
        .addInput(addInput),
        .addRefInput(addRefInput),
        .inputData(inputData),
        .refInputData(refInputData),
        .fifoFull(fifoFull),
        .inputFull(inputFull),
        .refInputFull(refInputFull),
        .push(push),
        .pushData(pushData)
    );

    rayOutputFifo rayOutputFifo_i (
        .clk(clk),
        .resetn(resetn),
        .push(push),
        .pushData(pushData),
        .full(fifoFull),
        .read(outRead),
        .empty(outEmpty),
        .headData(outData)
    );

endmodule

//--- clockGen.sv
module clockGen (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int resetCycles = 3;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released on a rising edge
    initial begin
        resetn = 1'b0;
        repeat (resetCycles) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- surfaceRayStage_tb.sv
module surfaceRayStage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rayTypesPkg::*;

    // Slot selection to push in the generator
    localparam int genLatency = 1 + 100 + 1;

    // One ray line of the stimulus file
    typedef struct packed {
        int testId;
        logic isRef;
        logic [1:0] readMode;
        surfaceInputT inRay;
        fixed3T expInv;
    } stimEntryT;

    logic clk;
    logic resetn;
    logic addInput;
    logic addRefInput;
    surfaceInputT inputData;
    surfaceInputT refInputData;
    logic inputFull;
    logic refInputFull;
    logic outRead;
    logic outEmpty;
    surfaceInputT outData;

    stimEntryT stim[$];
    int testIds[$];
    int errorCount = 0;
    int testsOk = 0;
    int testsBad = 0;
    int cycleCount = 0;
    int cycleLimit = 200;
    int raysAdded = 0;
    int unsigned rngState = 29;
    logic loadOk;

    clockGen clockGen_i (
        .clk(clk),
        .resetn(resetn)
    );

    surfaceRayStage surfaceRayStage_i (
        .clk(clk),
        .resetn(resetn),
        .addInput(addInput),
        .addRefInput(addRefInput),
        .inputData(inputData),
        .refInputData(refInputData),
        .inputFull(inputFull),
        .refInputFull(refInputFull),
        .outRead(outRead),
        .outEmpty(outEmpty),
        .outData(outData)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic int unsigned lcgNext(input int unsigned s);
        lcgNext = s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %b expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareFixed(input string name, input fixedT got, input fixedT exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // Pass-through fields compared as one record and invDir per component
    task automatic compareRay(input string name, input surfaceInputT got,
                              input surfaceInputT exp);
        surfaceInputT gotRest;
        surfaceInputT expRest;
        gotRest = got;
        expRest = exp;
        gotRest.ray.invDir = '0;
        expRest.ray.invDir = '0;
        if (gotRest !== expRest) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, gotRest, expRest);
            errorCount++;
        end
        compareFixed({name, ".ray.invDir.x"}, got.ray.invDir.x, exp.ray.invDir.x);
        compareFixed({name, ".ray.invDir.y"}, got.ray.invDir.y, exp.ray.invDir.y);
        compareFixed({name, ".ray.invDir.z"}, got.ray.invDir.z, exp.ray.invDir.z);
    endtask

    task automatic loadStimulus(output logic ok);
        int fd;
        int n;
        int tid;
        int src;
        int mode;
        string line;
        logic [31:0] w [11];
        stimEntryT e;
        fd = $fopen("surfaceRay_stimulus.txt", "r");
        ok = fd != 0;
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %h %h %h %h %h %h %h %h %h %h %h",
                                tid, src, mode, w[0], w[1], w[2], w[3], w[4], w[5],
                                w[6], w[7], w[8], w[9], w[10]);
                    if (n == 14) begin
                        e.testId = tid;
                        e.isRef = src != 0;
                        e.readMode = mode[1:0];
                        e.inRay.ray.origin = {w[0], w[1], w[2]};
                        e.inRay.ray.dir = {w[3], w[4], w[5]};
                        // Junk that the generator has to overwrite
                        e.inRay.ray.invDir = '1;
                        e.inRay.pixelIndex = w[6][15:0];
                        e.inRay.bounceDepth = w[7][3:0];
                        e.expInv = {w[8], w[9], w[10]};
                        stim.push_back(e);
                        if (testIds.size() == 0 || testIds[$] != tid) begin
                            testIds.push_back(tid);
                        end
                    end
                end
            end
            $fclose(fd);
            ok = stim.size() > 0;
        end
    endtask

    task automatic reportTest(input int testId, input int rays, input logic ok);
        if (ok) begin
            testsOk++;
            $display("test %0d: ok, %0d rays", testId, rays);
        end else begin
            testsBad++;
            $display("test %0d: failed, %0d rays", testId, rays);
        end
    endtask

    function automatic void findRay(input logic [15:0] pix, input int primIdx[$],
                                    input int refIdx[$], output int pos, output logic fromRef);
        pos = -1;
        fromRef = 1'b0;
        foreach (primIdx[k]) begin
            if (stim[primIdx[k]].inRay.pixelIndex == pix) begin
                pos = k;
            end
        end
        foreach (refIdx[k]) begin
            if (stim[refIdx[k]].inRay.pixelIndex == pix) begin
                pos = k;
                fromRef = 1'b1;
            end
        end
    endfunction

    // --------------------------------------------------
    // Sources and consumer
    // --------------------------------------------------

    task automatic feedSource(input int idxList[$], input logic isRef);
        foreach (idxList[i]) begin
            @(negedge clk);
            while (isRef ? refInputFull : inputFull) begin
                @(negedge clk);
            end
            @(posedge clk);
            if (isRef) begin
                addRefInput <= 1'b1;
                refInputData <= stim[idxList[i]].inRay;
            end else begin
                addInput <= 1'b1;
                inputData <= stim[idxList[i]].inRay;
            end
            @(posedge clk);
            if (isRef) begin
                addRefInput <= 1'b0;
            end else begin
                addInput <= 1'b0;
            end
            raysAdded++;
        end
    endtask

    // Mode 0 reads at once, 1 waits for full FIFO and generator, 2 stalls at random
    task automatic collectRays(input int primIdx[$], input int refIdx[$],
                               input logic [1:0] mode);
        int total;
        int received;
        int gotPrim;
        int gotRef;
        int pos;
        int idx;
        logic fromRef;
        logic takeIt;
        surfaceInputT expRay;
        total = primIdx.size() + refIdx.size();
        received = 0;
        gotPrim = 0;
        gotRef = 0;
        if (mode == 2'd1) begin
            // Last ray taken by the generator and held in its done state
            @(negedge clk);
            while (raysAdded < total || inputFull || refInputFull) begin
                @(negedge clk);
            end
            repeat (genLatency + 2) @(negedge clk);
        end
        while (received < total) begin
            @(negedge clk);
            takeIt = !outEmpty;
            if (mode == 2'd2) begin
                rngState = lcgNext(rngState);
                takeIt = takeIt && rngState[16];
            end
            if (takeIt) begin
                findRay(outData.pixelIndex, primIdx, refIdx, pos, fromRef);
                if (pos < 0) begin
                    $display("Ray with pixelIndex %h at %0t does not belong to this test",
                             outData.pixelIndex, $time);
                    errorCount++;
                end else begin
                    idx = fromRef ? refIdx[pos] : primIdx[pos];
                    expRay = stim[idx].inRay;
                    expRay.ray.invDir = stim[idx].expInv;
                    compareRay("outData", outData, expRay);
                    // Reflection goes first when both sources start together
                    if (received == 0 && primIdx.size() > 0 && refIdx.size() > 0 && !fromRef) begin
                        $display("Primary ray left ahead of the waiting reflection ray at %0t",
                                 $time);
                        errorCount++;
                    end
                    if (pos != (fromRef ? gotRef : gotPrim)) begin
                        $display("Ray with pixelIndex %h at %0t is out of order in its source",
                                 outData.pixelIndex, $time);
                        errorCount++;
                    end
                    if (fromRef) begin
                        gotRef++;
                    end else begin
                        gotPrim++;
                    end
                end
                @(posedge clk);
                outRead <= 1'b1;
                @(posedge clk);
                outRead <= 1'b0;
                received++;
            end
        end
    endtask

    task automatic runTest(input int testId);
        int primIdx[$];
        int refIdx[$];
        int startErrors;
        logic [1:0] mode;
        mode = 2'd0;
        foreach (stim[i]) begin
            if (stim[i].testId == testId) begin
                if (stim[i].isRef) begin
                    refIdx.push_back(i);
                end else begin
                    primIdx.push_back(i);
                end
                mode = stim[i].readMode;
            end
        end
        startErrors = errorCount;
        raysAdded = 0;
        fork
            feedSource(primIdx, 1'b0);
            feedSource(refIdx, 1'b1);
            collectRays(primIdx, refIdx, mode);
        join
        reportTest(testId, primIdx.size() + refIdx.size(), errorCount == startErrors);
    endtask

    task automatic checkReset();
        int startErrors;
        startErrors = errorCount;
        wait (resetn === 1'b1);
        @(negedge clk);
        compareFlag("inputFull", inputFull, 1'b0);
        compareFlag("refInputFull", refInputFull, 1'b0);
        compareFlag("outEmpty", outEmpty, 1'b1);
        reportTest(1, 0, errorCount == startErrors);
    endtask

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the expected rays never all came out", cycleLimit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        addInput = 1'b0;
        addRefInput = 1'b0;
        inputData = '0;
        refInputData = '0;
        outRead = 1'b0;
        loadStimulus(loadOk);
        cycleLimit = 150 * stim.size() + 200;
        if (!loadOk) begin
            $display("Could not read any rays from surfaceRay_stimulus.txt");
            $display("Result: FAILED");
        end else begin
            checkReset();
            foreach (testIds[i]) begin
                runTest(testIds[i]);
            end
            $display("Tests: %0d run, %0d ok, %0d failed, %0d check errors",
                     testsOk + testsBad, testsOk, testsBad, errorCount);
            if (testsBad == 0 && errorCount == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

endmodule

//--- surfaceRay_stimulus.txt
# test src mode | origin x y z | dir x y z | pixelIndex bounceDepth | expected invDir x y z
# src 0 primary 1 reflection; mode 0 read at once, 1 hold reads until FIFO full, 2 random stalls
# test 2: one primary ray
2 0 0 10000 20000 30000 10000 fffc0000 8000 0101 0 10000 ffffc000 20000
# test 3: saturation and truncation
3 0 0 0 0 0 0 1 ffffffff 0201 0 7fffffff 7fffffff 80000000
3 0 0 50000 fff00000 0 2 fffffffe 3 0202 0 7fffffff 80000000 55555555
3 0 0 1234 5678 9abc 30000 fffd0000 a0000 0203 0 5555 ffffaaab 1999
3 0 0 ffff0000 0 10000 7fffffff 80000000 640000 0204 0 2 fffffffe 28f
# test 4: both sources in the same cycle
4 0 0 0 0 0 18000 c000 ffff4000 0301 0 aaaa 15555 fffeaaab
4 1 0 20000 10000 0 50000 70000 ffffe000 0302 1 3333 2492 fff80000
# test 5: five rays with the consumer held off
5 0 1 10000 0 0 10000 20000 4000 0401 0 10000 8000 40000
5 0 1 20000 0 0 10 fff00000 c0000 0402 0 10000000 fffff000 1555
5 0 1 30000 0 0 30000 30000 30000 0403 0 5555 5555 5555
5 0 1 40000 0 0 ffff0000 8000 100 0404 0 ffff0000 20000 1000000
5 0 1 50000 0 0 40000 fffe0000 1 0405 0 4000 ffff8000 7fffffff
# test 6: mixed stream with random read stalls
6 0 2 0 0 10000 a0000 10000 20000 0501 0 1999 10000 8000
6 1 2 0 10000 0 8000 ffff0000 30000 0502 1 20000 ffff0000 5555
6 0 2 10000 0 0 50000 fffb0000 10000 0503 0 3333 ffffcccd 10000
6 1 2 0 0 20000 70000 4000 ffffc000 0504 2 2492 40000 fffc0000
6 0 2 fffe0000 0 0 18000 18000 ffff0000 0505 0 aaaa aaaa ffff0000
6 1 2 0 fffe0000 0 20000 0 c000 0506 3 8000 7fffffff 15555
6 0 2 0 0 fffe0000 fffc0000 3 2 0507 0 ffffc000 55555555 7fffffff
6 1 2 30000 30000 30000 100 10 1 0508 2 1000000 10000000 7fffffff

//--- project.f
+incdir+.
rayTypesPkg.sv
fixedReciprocal.sv
fixed3Reciprocal.sv
surfaceRayGenerator.sv
rayOutputFifo.sv
surfaceRayStage.sv
clockGen.sv
surfaceRayStage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= surfaceRayStage_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
